/* hw/rtcDisplayPkg.sv */
`default_nettype none

package rtcDisplayPkg;

    // VGA 640x480 timing in pixel clocks, both syncs active low
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800 clocks per line

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525 lines per frame

    localparam int COORD_W = 10;
    typedef logic [COORD_W-1:0] pixelCoord;

    // RTC fields in Wishbone address order
    localparam int FIELD_COUNT = 6;
    localparam int FIELD_SEC   = 0;
    localparam int FIELD_MIN   = 1;
    localparam int FIELD_HOUR  = 2;
    localparam int FIELD_DATE  = 3;
    localparam int FIELD_MONTH = 4;
    localparam int FIELD_YEAR  = 5;
    localparam int FIELD_MAX   = 99;               // Two decimal digits at most

    typedef logic [6:0] asciiChar;
    typedef asciiChar [1:0] fieldDigits;
    localparam int DIGIT_TENS  = 1;
    localparam int DIGIT_UNITS = 0;

    // "hh:mm:ss  DD:MM:YY"
    localparam int TEXT_LEN = 18;

    // Font ROM holds '0'..'9' and ':' only
    localparam asciiChar GLYPH_BASE = 7'h30;
    localparam int GLYPH_COUNT  = 11;
    localparam int FONT_ROWS    = 8;
    localparam int GLYPH_IDX_W  = $clog2(GLYPH_COUNT);
    localparam int ROW_W        = $clog2(FONT_ROWS);
    localparam int GLYPH_ADDR_W = GLYPH_IDX_W + ROW_W;  // Glyph index above row

    typedef logic [11:0] rgbColor;                  // 4 bits each of R, G, B
    localparam rgbColor COLOR_FG = 12'hFFE;
    localparam rgbColor COLOR_BG = 12'h111;

endpackage

`default_nettype wire

/* hw/vgaTimingIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Raw timing straight from the counters, same cycle
interface vgaTimingIf;
    import rtcDisplayPkg::*;

    logic      hsync;      // Active low
    logic      vsync;      // Active low
    logic      videoOn;
    pixelCoord pixelX;
    pixelCoord pixelY;
    logic      frameEnd;   // First cycle of line 480

    modport source (
        output hsync, vsync, videoOn, pixelX, pixelY, frameEnd
    );

    modport sink (
        input hsync, vsync, videoOn, pixelX, pixelY, frameEnd
    );

endinterface

`default_nettype wire

/* hw/vgaSync.sv */
`timescale 1ns/1ps
`default_nettype none

module vgaSync (
    input  logic clk,
    input  logic rst,
    vgaTimingIf.source timing
);
    import rtcDisplayPkg::*;

    // Sync pulse windows inside the line and the frame
    localparam pixelCoord HS_START = pixelCoord'(H_ACTIVE + H_FRONT);
    localparam pixelCoord HS_END   = pixelCoord'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam pixelCoord VS_START = pixelCoord'(V_ACTIVE + V_FRONT);
    localparam pixelCoord VS_END   = pixelCoord'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam pixelCoord H_LAST   = pixelCoord'(H_TOTAL - 1);
    localparam pixelCoord V_LAST   = pixelCoord'(V_TOTAL - 1);

    pixelCoord hCount;   // 0..799
    pixelCoord vCount;   // 0..524
    logic      lineEnd;

    assign lineEnd = (hCount == H_LAST);

    ////////////////////////////////////////////////////////////
    // Pixel and line counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            if (lineEnd) begin
                hCount <= '0;
            end else begin
                hCount <= hCount + 1'b1;
            end

            if (lineEnd) begin          // Line count steps once per line
                if (vCount == V_LAST) begin
                    vCount <= '0;
                end else begin
                    vCount <= vCount + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Decoded timing, unregistered
    ////////////////////////////////////////////////////////////

    // Renderer pipeline registers these along with the pixel
    assign timing.hsync   = ~((hCount >= HS_START) && (hCount < HS_END));
    assign timing.vsync   = ~((vCount >= VS_START) && (vCount < VS_END));
    assign timing.videoOn = (hCount < pixelCoord'(H_ACTIVE))
                            && (vCount < pixelCoord'(V_ACTIVE));

    assign timing.pixelX = hCount;
    assign timing.pixelY = vCount;

    // Start of vertical blanking, one clock only
    assign timing.frameEnd = (vCount == pixelCoord'(V_ACTIVE)) && (hCount == '0);

endmodule

`default_nettype wire

/* hw/rtcFieldRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module rtcFieldRegs (
    input  logic       clk,
    input  logic       rst,
    input  logic       frameEnd,
    input  logic       wbCyc,
    input  logic       wbStb,
    input  logic       wbWe,
    input  logic [2:0] wbAdr,
    input  logic [7:0] wbDatW,
    output logic [7:0] wbDatR,
    output logic       wbAck,
    output rtcDisplayPkg::fieldDigits fieldText [rtcDisplayPkg::FIELD_COUNT]
);
    import rtcDisplayPkg::*;

    localparam int VALUE_W = $clog2(FIELD_MAX + 1);   // 7 bits hold 0..99

    logic [VALUE_W-1:0] shadow [FIELD_COUNT];         // Binary values, bus side
    fieldDigits         shadowText [FIELD_COUNT];     // Same values as ASCII

    logic request;
    logic fieldHit;
    logic inRange;

    ////////////////////////////////////////////////////////////
    // Wishbone classic slave
    ////////////////////////////////////////////////////////////

    // New request only while ack is low, so ack never stretches
    assign request  = wbCyc & wbStb & ~wbAck;
    assign fieldHit = (wbAdr < 3'(FIELD_COUNT));      // 6 and 7 are holes
    assign inRange  = (wbDatW <= 8'(FIELD_MAX));

    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request;
        end
    end

    // Write lands together with the ack
    always_ff @(posedge clk) begin
        for (int i = 0; i < FIELD_COUNT; i++) begin
            if (rst) begin
                shadow[i] <= '0;
            end else if (request && wbWe && fieldHit && inRange
                         && (wbAdr == 3'(i))) begin
                shadow[i] <= VALUE_W'(wbDatW);
            end
        end
    end

    // Read data valid in the ack cycle
    always_ff @(posedge clk) begin
        if (request) begin
            wbDatR <= fieldHit ? 8'(shadow[wbAdr]) : 8'h00;  // Holes read as zero
        end
    end

    ////////////////////////////////////////////////////////////
    // Binary to ASCII, then commit at vertical blanking
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < FIELD_COUNT; i++) begin
            shadowText[i][DIGIT_TENS]  = GLYPH_BASE + asciiChar'(shadow[i] / VALUE_W'(10));
            shadowText[i][DIGIT_UNITS] = GLYPH_BASE + asciiChar'(shadow[i] % VALUE_W'(10));
        end
    end

    // Whole set swaps at once, no torn frame
    always_ff @(posedge clk) begin
        for (int i = 0; i < FIELD_COUNT; i++) begin
            if (rst) begin
                fieldText[i] <= {GLYPH_BASE, GLYPH_BASE};   // "00"
            end else if (frameEnd) begin
                fieldText[i] <= shadowText[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fontRom.sv */
`timescale 1ns/1ps
`default_nettype none

module fontRom (
    input  logic clk,
    input  logic [rtcDisplayPkg::GLYPH_ADDR_W-1:0] glyphAddr,
    output logic [7:0] glyphRow
);
    import rtcDisplayPkg::*;

    localparam int DEPTH = GLYPH_COUNT * FONT_ROWS;   // 88 row bytes

    // '0'..'9' then ':', top row first, MSB is the left pixel
    logic [7:0] rom [DEPTH];

    initial begin
        $readmemh("hw/fontDigits.hex", rom);
    end

    // Registered read, one clock of latency
    always_ff @(posedge clk) begin
        glyphRow <= rom[glyphAddr];
    end

endmodule

`default_nettype wire

/* hw/textRenderer.sv */
`timescale 1ns/1ps
`default_nettype none

module textRenderer #(
    parameter int textOriginX = 256,
    parameter int textOriginY = 232
) (
    input  logic clk,
    input  logic rst,
    vgaTimingIf.sink timing,
    input  rtcDisplayPkg::fieldDigits fieldText [rtcDisplayPkg::FIELD_COUNT],
    output logic [rtcDisplayPkg::GLYPH_ADDR_W-1:0] glyphAddr,
    input  logic [7:0] glyphRow,
    output logic hsync,
    output logic vsync,
    output logic videoOn,
    output rtcDisplayPkg::rgbColor rgb
);
    import rtcDisplayPkg::*;

    localparam int CELL_W     = 8;                    // 8x8 font
    localparam int CELL_SHIFT = $clog2(CELL_W);

    localparam pixelCoord TEXT_X0 = pixelCoord'(textOriginX);
    localparam pixelCoord TEXT_X1 = pixelCoord'(textOriginX + TEXT_LEN * CELL_W);
    localparam pixelCoord TEXT_Y0 = pixelCoord'(textOriginY);
    localparam pixelCoord TEXT_Y1 = pixelCoord'(textOriginY + FONT_ROWS);

    localparam asciiChar CHAR_COLON = 7'h3A;
    localparam asciiChar CHAR_SPACE = 7'h20;

    pixelCoord relX;
    pixelCoord relY;
    logic [COORD_W-CELL_SHIFT-1:0] charIdx;           // Cell along the line
    asciiChar charCode;
    logic inBox;
    logic isGlyph;
    logic [GLYPH_IDX_W-1:0] glyphIdx;

    // Stage 1, aligned with the ROM read
    logic                  d1Glyph;
    logic                  d1Video;
    logic                  d1Hsync;
    logic                  d1Vsync;
    logic [CELL_SHIFT-1:0] d1Col;

    ////////////////////////////////////////////////////////////
    // Character cell lookup
    ////////////////////////////////////////////////////////////

    assign relX    = timing.pixelX - TEXT_X0;
    assign relY    = timing.pixelY - TEXT_Y0;
    assign charIdx = relX[COORD_W-1:CELL_SHIFT];

    assign inBox = timing.videoOn
                   && (timing.pixelX >= TEXT_X0) && (timing.pixelX < TEXT_X1)
                   && (timing.pixelY >= TEXT_Y0) && (timing.pixelY < TEXT_Y1);

    always_comb begin
        case (charIdx)
            0:  charCode = fieldText[FIELD_HOUR][DIGIT_TENS];
            1:  charCode = fieldText[FIELD_HOUR][DIGIT_UNITS];
            3:  charCode = fieldText[FIELD_MIN][DIGIT_TENS];
            4:  charCode = fieldText[FIELD_MIN][DIGIT_UNITS];
            6:  charCode = fieldText[FIELD_SEC][DIGIT_TENS];
            7:  charCode = fieldText[FIELD_SEC][DIGIT_UNITS];
            10: charCode = fieldText[FIELD_DATE][DIGIT_TENS];
            11: charCode = fieldText[FIELD_DATE][DIGIT_UNITS];
            13: charCode = fieldText[FIELD_MONTH][DIGIT_TENS];
            14: charCode = fieldText[FIELD_MONTH][DIGIT_UNITS];
            16: charCode = fieldText[FIELD_YEAR][DIGIT_TENS];
            17: charCode = fieldText[FIELD_YEAR][DIGIT_UNITS];
            2, 5, 12, 15: charCode = CHAR_COLON;
            default: charCode = CHAR_SPACE;            // Gap at 8 and 9
        endcase
    end

    // Spaces never touch the ROM
    assign isGlyph   = inBox && (charCode != CHAR_SPACE);
    assign glyphIdx  = isGlyph ? GLYPH_IDX_W'(charCode - GLYPH_BASE) : '0;
    assign glyphAddr = {glyphIdx, relY[ROW_W-1:0]};

    ////////////////////////////////////////////////////////////
    // Two-stage pixel pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            d1Glyph <= 1'b0;
            d1Video <= 1'b0;
            d1Hsync <= 1'b1;
            d1Vsync <= 1'b1;
        end else begin
            d1Glyph <= isGlyph;
            d1Video <= timing.videoOn;
            d1Hsync <= timing.hsync;
            d1Vsync <= timing.vsync;
        end
        d1Col <= relX[CELL_SHIFT-1:0];                 // Column inside the cell
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            videoOn <= 1'b0;
            rgb     <= '0;
        end else begin
            hsync   <= d1Hsync;
            vsync   <= d1Vsync;
            videoOn <= d1Video;
            if (!d1Video) begin
                rgb <= '0;                             // Black during blanking
            end else if (d1Glyph && glyphRow[~d1Col]) begin  // Leftmost pixel is bit 7
                rgb <= COLOR_FG;
            end else begin
                rgb <= COLOR_BG;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rtcDisplayTop.sv */
`timescale 1ns/1ps
`default_nettype none

module rtcDisplayTop #(
    parameter int textOriginX = 256,
    parameter int textOriginY = 232
) (
    input  logic       clk,
    input  logic       rst,
    // Wishbone classic slave
    input  logic       wbCyc,
    input  logic       wbStb,
    input  logic       wbWe,
    input  logic [2:0] wbAdr,
    input  logic [7:0] wbDatW,
    output logic [7:0] wbDatR,
    output logic       wbAck,
    // VGA out
    output logic       hsync,
    output logic       vsync,
    output logic       videoOn,
    output rtcDisplayPkg::rgbColor rgb
);
    import rtcDisplayPkg::*;

    vgaTimingIf timing ();

    logic                    frameEnd;
    fieldDigits              fieldText [FIELD_COUNT];   // Display copy
    logic [GLYPH_ADDR_W-1:0] glyphAddr;
    logic [7:0]              glyphRow;

    assign frameEnd = timing.frameEnd;

    vgaSync syncGen (
        .clk    (clk),
        .rst    (rst),
        .timing (timing.source)
    );

    rtcFieldRegs fieldRegs (
        .clk       (clk),
        .rst       (rst),
        .frameEnd  (frameEnd),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .fieldText (fieldText)
    );

    textRenderer #(
        .textOriginX (textOriginX),
        .textOriginY (textOriginY)
    ) renderer (
        .clk       (clk),
        .rst       (rst),
        .timing    (timing.sink),
        .fieldText (fieldText),
        .glyphAddr (glyphAddr),
        .glyphRow  (glyphRow),
        .hsync     (hsync),
        .vsync     (vsync),
        .videoOn   (videoOn),
        .rgb       (rgb)
    );

    fontRom font (
        .clk       (clk),
        .glyphAddr (glyphAddr),
        .glyphRow  (glyphRow)
    );

endmodule

`default_nettype wire

/* test/rtcDisplayTb_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module rtcDisplayTb_assert (
    input logic        clk,
    input logic        rst,
    input logic        wbCyc,
    input logic        wbStb,
    input logic        wbAck,
    input logic        videoOn,
    input logic [11:0] rgb
);

    ////////////////////////////////////////////////////////////
    // Wishbone handshake
    ////////////////////////////////////////////////////////////

    // Ack answers a request seen one clock earlier
    ackAfterRequest: assert property (@(posedge clk) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb))
        else $error("wbAck raised without a request in the previous cycle");

    ackOneCycle: assert property (@(posedge clk) disable iff (rst)
        wbAck |=> !wbAck)                          // Never stretched
        else $error("wbAck held for two cycles");

    ////////////////////////////////////////////////////////////
    // Video blanking
    ////////////////////////////////////////////////////////////

    blankIsBlack: assert property (@(posedge clk) disable iff (rst)
        !videoOn |-> (rgb == 12'h000))
        else $error("rgb not black while videoOn is low");

endmodule

bind rtcDisplayTop rtcDisplayTb_assert busVideoChecks (
    .clk     (clk),
    .rst     (rst),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbAck   (wbAck),
    .videoOn (videoOn),
    .rgb     (rgb)
);

`default_nettype wire

/* test/rtcDisplayTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rtcDisplayTb;

    localparam int TEXT_X       = 200;            // Text origin handed to the DUT
    localparam int TEXT_Y       = 120;
    localparam int H_VISIBLE    = 640;
    localparam int V_VISIBLE    = 480;
    localparam int H_TOTAL      = 800;
    localparam int H_PULSE      = 96;             // hsync low time
    localparam int H_BACK       = 48;
    localparam int V_PULSE      = 2 * 800;        // vsync low time in clocks
    localparam int VSYNC_LEAD   = (16 + 96 + 48) + 10 * 800;  // Blank clocks before vsync
    localparam int FRAME_CYCLES = 800 * 525;
    localparam int COMMIT_LEAD  = 10 * 800 + 4;   // Blanking start to output vsync, plus slack
    localparam int FG           = 'hFFE;
    localparam int BG           = 'h111;

    logic        clk;
    logic        rst;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [2:0]  wbAdr;
    logic [7:0]  wbDatW;
    logic [7:0]  wbDatR;
    logic        wbAck;
    logic        hsync;
    logic        vsync;
    logic        videoOn;
    logic [11:0] rgb;

    logic [7:0] font [88];                        // Same glyph data as the ROM
    int    fieldVal [6];                          // Last accepted value per field
    string expText;                               // Line expected on the checked frame

    byte cmdKind [$];
    int  cmdAdr [$];
    int  cmdDat [$];

    int cycleCount      = 0;
    int cycleLimit      = 0;
    int lastWriteCycle  = 0;
    int framesRequested = 0;
    int framesStarted   = 0;
    int framesChecked   = 0;

    // Output position tracking
    int   col        = 0;
    int   lineCount  = 0;
    int   hPos       = -1;                        // Clocks since hsync fell, -1 before the first
    int   vsyncLow   = 0;
    int   sinceVideo = 0;
    logic prevHsync  = 1'b1;
    logic prevVsync  = 1'b1;
    logic prevVideo  = 1'b0;
    logic checking   = 1'b0;

    rtcDisplayTop #(
        .textOriginX (TEXT_X),
        .textOriginY (TEXT_Y)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbDatW  (wbDatW),
        .wbDatR  (wbDatR),
        .wbAck   (wbAck),
        .hsync   (hsync),
        .vsync   (vsync),
        .videoOn (videoOn),
        .rgb     (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                   // 100 ns period
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic compare(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("ERROR %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////

    task automatic busCycle(input logic we, input int adr, input int dat, output int rdData);
        int   waited;
        logic acked;
        @(posedge clk);
        #1;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr[2:0];
        wbDatW = dat[7:0];
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < 2) begin        // Ack due within two cycles
            @(negedge clk);
            acked = wbAck;
            waited++;
        end
        compare(int'(acked), 1, $sformatf("acknowledge for address %0d", adr));
        rdData = int'(wbDatR);                    // Valid alongside the ack
        @(posedge clk);
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    // Colour of one visible pixel from the text layout and the font
    function automatic int expectedPixel(int x, int y);
        int         glyph;
        byte        ch;
        logic [6:0] romIdx;
        logic [2:0] bitPos;
        logic [7:0] row;
        if (x < TEXT_X || x >= TEXT_X + expText.len() * 8 || y < TEXT_Y || y >= TEXT_Y + 8) begin
            return BG;
        end
        ch = expText[(x - TEXT_X) / 8];
        if (ch == " ") begin
            return BG;                            // Gap between time and date
        end
        glyph  = int'(ch) - 'h30;                 // ':' lands right after '9'
        romIdx = 7'(glyph * 8 + (y - TEXT_Y));
        bitPos = 3'(7 - ((x - TEXT_X) % 8));      // Left pixel is the MSB
        row    = font[romIdx];
        return row[bitPos] ? FG : BG;
    endfunction

    ////////////////////////////////////////////////////////////
    // Screen checker
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            // Horizontal timing measured from each hsync falling edge
            if (prevHsync && !hsync) begin
                if (hPos >= 0) begin
                    compare(hPos, H_TOTAL, "clocks between hsync pulses");
                end
                hPos = 0;
            end
            if (hPos >= 0) begin
                compare(int'(hsync), int'(hPos >= H_PULSE), "hsync level");
                if (videoOn && !prevVideo) begin
                    compare(hPos, H_PULSE + H_BACK, "hsync to first visible pixel");
                end
            end
            if (!prevVsync && vsync) begin
                compare(vsyncLow, V_PULSE, "vsync pulse length");
            end
            if (prevVsync && !vsync) begin
                compare(lineCount, V_VISIBLE, "visible lines in the frame");
                compare(sinceVideo, VSYNC_LEAD, "blank clocks before vsync");
                lineCount = 0;
                // Frame after this pulse holds every write only if blanking began after them
                if (framesRequested > framesStarted
                    && cycleCount - lastWriteCycle > COMMIT_LEAD) begin
                    expText = $sformatf("%02d:%02d:%02d  %02d:%02d:%02d",
                                        fieldVal[2], fieldVal[1], fieldVal[0],
                                        fieldVal[3], fieldVal[4], fieldVal[5]);
                    checking = 1'b1;
                    framesStarted++;
                end
            end
            if (videoOn) begin
                if (checking) begin
                    compare(int'(rgb), expectedPixel(col, lineCount),
                            $sformatf("pixel x=%0d y=%0d", col, lineCount));
                end
                col++;
            end else begin
                compare(int'(rgb), 0, "rgb while videoOn is low");
                if (prevVideo) begin              // End of a visible line
                    compare(col, H_VISIBLE, "visible pixels in the line");
                    col = 0;
                    lineCount++;
                    if (checking && lineCount == V_VISIBLE) begin
                        checking = 1'b0;
                        framesChecked++;
                    end
                end
            end
            if (hPos >= 0) begin
                hPos++;
            end
            vsyncLow   = vsync ? 0 : vsyncLow + 1;
            sinceVideo = videoOn ? 0 : sinceVideo + 1;
            prevHsync  = hsync;
            prevVsync  = vsync;
            prevVideo  = videoOn;
        end
    end

    ////////////////////////////////////////////////////////////
    // Case file and command sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    nItems;
        int    frameChecks;
        int    adr;
        int    dat;
        int    rdData;
        byte   kind;
        string line;

        rst    = 1'b1;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        foreach (fieldVal[i]) begin
            fieldVal[i] = 0;                      // Reset value of every field
        end
        $readmemh("hw/fontDigits.hex", font);

        frameChecks = 0;
        fd = $fopen("test/rtcDisplayCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/rtcDisplayCases.txt");
            $display("sim failed");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                         // Comment or blank line
            end
            nItems = $sscanf(line, "%c %h %h", kind, adr, dat);
            if (nItems != 3 || (kind != "W" && kind != "R" && kind != "F")) begin
                $display("Malformed line in the cases file: %s", line);
                $display("sim failed");
                $fatal(1, "bad stimulus");
            end
            cmdKind.push_back(kind);
            cmdAdr.push_back(adr);
            cmdDat.push_back(dat);
            if (kind == "F") begin
                frameChecks++;
            end
        end
        $fclose(fd);
        cycleLimit = (frameChecks + 3) * FRAME_CYCLES;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (cmdKind[i]) begin
            adr = cmdAdr[i];
            dat = cmdDat[i];
            case (cmdKind[i])
                "W": begin
                    busCycle(1'b1, adr, dat, rdData);
                    if (adr < 6 && dat <= 99) begin   // Out-of-range data and holes dropped
                        fieldVal[3'(adr)] = dat;
                    end
                    lastWriteCycle = cycleCount;
                end
                "R": begin
                    busCycle(1'b0, adr, dat, rdData);
                    compare(rdData, dat, $sformatf("read back of address %0d", adr));
                end
                default: begin
                    framesRequested++;
                    wait (framesChecked == framesRequested);
                end
            endcase
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/fontDigits.hex */
// One glyph per line, '0' to '9' then ':', eight row bytes top to bottom, MSB is the left pixel
3C 66 6E 76 66 66 3C 00
18 38 18 18 18 18 7E 00
3C 66 06 0C 18 30 7E 00
3C 66 06 1C 06 66 3C 00
0C 1C 3C 6C 7E 0C 0C 00
7E 60 7C 06 06 66 3C 00
1C 30 60 7C 66 66 3C 00
7E 06 0C 18 30 30 30 00
3C 66 66 3C 66 66 3C 00
3C 66 66 3E 06 0C 38 00
00 18 18 00 00 18 18 00

/* rtcDisplay.f */
hw/rtcDisplayPkg.sv
hw/vgaTimingIf.sv
hw/vgaSync.sv
hw/rtcFieldRegs.sv
hw/fontRom.sv
hw/textRenderer.sv
hw/rtcDisplayTop.sv
test/rtcDisplayTb_assert.sv
test/rtcDisplayTb.sv

/* Makefile */
TOP = rtcDisplayTb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rtcDisplay.f -o Vsim
	./obj_dir/Vsim

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* test/rtcDisplayCases.txt */
# Columns: command, address (hex), data (hex)
# W writes data, R reads and expects data, F checks the next frame after the commit
F 0 00
R 2 00
W 0 2D
W 1 3B
W 2 17
W 3 1F
W 4 0C
W 5 63
R 0 2D
R 1 3B
R 2 17
R 3 1F
R 4 0C
R 5 63
W 1 64
W 5 FF
R 1 3B
R 5 63
W 6 12
W 7 34
R 6 00
R 7 00
F 0 00
W 2 08
W 0 07
W 3 01
F 0 00
